// ==== compile.f ====
verilog/core_pkg.sv
verilog/lsq_pkg.sv
verilog/store_buffer.sv
verilog/store_agu.sv
verilog/load_unit.sv
verilog/data_mem.sv
verilog/lsu_top.sv
dv/lsu_checker.sv
dv/lsu_tb.sv

// ==== dv/lsu_tb.sv ====
`timescale 1ns/1ns

module lsu_tb;
    import core_pkg::*;
    import lsq_pkg::*;

    localparam int RAND_OPS    = 300;
    localparam int TEST_CYCLES = 40 + 30 + 30 + 40 + 20 + RAND_OPS + 60;

    typedef struct packed {
        sb_idx_t tag;
        logic    wb;
        word_t   addr;
        word_t   data;
    } model_entry_t;

    logic      clk_i = 1'b0;
    logic      reset_i;
    logic      st_issue_v_i;
    st_issue_t st_issue_i;
    logic      st_ready_o;
    sb_idx_t   st_entry_o;
    logic      ld_issue_v_i;
    ld_req_t   ld_issue_i;
    logic      ld_done_o;
    ld_res_t   ld_res_o;
    logic      rob_commit_st_i;
    logic      rob_mispredict_i;
    logic      mem_wr_v_o;
    word_t     mem_wr_addr_o;
    word_t     mem_wr_data_o;

    // reference model, buffer in age order
    model_entry_t mq[$];
    word_t        model_mem [MEM_WORDS];
    sb_idx_t      alloc_tag;
    logic         wb_pend_v;
    model_entry_t wb_pend;
    logic         pend1_v;
    ld_req_t      pend1_req;
    logic         exp_ld_v;
    ld_res_t      exp_ld;
    logic         head_v;
    model_entry_t head;

    // stimulus side view of the buffer
    sb_idx_t sq_tag[$];
    int      sq_step[$];
    sb_idx_t next_tag;
    int      step;
    int      seed;
    int      tb_err;
    int      tests_run;
    int      err_base;
    int      chk_err;
    int      chk_cnt;

    always #10 clk_i = ~clk_i;

    lsu_top lsu_top_inst
    (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .st_issue_v_i     (st_issue_v_i),
        .st_issue_i       (st_issue_i),
        .st_ready_o       (st_ready_o),
        .st_entry_o       (st_entry_o),
        .ld_issue_v_i     (ld_issue_v_i),
        .ld_issue_i       (ld_issue_i),
        .ld_done_o        (ld_done_o),
        .ld_res_o         (ld_res_o),
        .rob_commit_st_i  (rob_commit_st_i),
        .rob_mispredict_i (rob_mispredict_i),
        .mem_wr_v_o       (mem_wr_v_o),
        .mem_wr_addr_o    (mem_wr_addr_o),
        .mem_wr_data_o    (mem_wr_data_o)
    );

    lsu_checker checker_inst
    (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .rob_commit_st_i  (rob_commit_st_i),
        .rob_mispredict_i (rob_mispredict_i),
        .head_v_i         (head_v),
        .head_wb_i        (head.wb),
        .head_addr_i      (head.addr),
        .head_data_i      (head.data),
        .exp_ld_v_i       (exp_ld_v),
        .exp_ld_i         (exp_ld),
        .ld_done_i        (ld_done_o),
        .ld_res_i         (ld_res_o),
        .mem_wr_v_i       (mem_wr_v_o),
        .mem_wr_addr_i    (mem_wr_addr_o),
        .mem_wr_data_i    (mem_wr_data_o),
        .err_cnt_o        (chk_err),
        .chk_cnt_o        (chk_cnt)
    );

    // youngest written-back store in the window, else the memory word
    function automatic ld_res_t expected_load(input ld_req_t req);
        word_t   addr;
        ld_res_t res;
        logic    in_window;
        addr      = req.base + req.offset;
        res.data  = model_mem[addr[BYTE_OFF_W +: MEM_IDX_W]];
        res.fwd   = 1'b0;
        in_window = req.has_older;
        foreach (mq[i])
        begin
            if (in_window && mq[i].wb && (mq[i].addr == addr))
            begin
                res.data = mq[i].data;
                res.fwd  = 1'b1;
            end
            if (mq[i].tag == req.newest)
            begin
                in_window = 1'b0;
            end
        end
        return res;
    endfunction

    always @(posedge clk_i)
    begin
        if (reset_i)
        begin
            mq.delete();
            alloc_tag = '0;
            wb_pend_v = 1'b0;
            pend1_v   = 1'b0;
            exp_ld_v <= 1'b0;
        end
        else
        begin
            // query sees the buffer and memory as they were before this edge
            exp_ld_v  <= pend1_v && !rob_mispredict_i;
            exp_ld    <= expected_load(pend1_req);
            pend1_v   = ld_issue_v_i && !rob_mispredict_i;
            pend1_req = ld_issue_i;
            if (rob_commit_st_i && (mq.size() > 0) && mq[0].wb)
            begin
                model_mem[mq[0].addr[BYTE_OFF_W +: MEM_IDX_W]] = mq[0].data;
                void'(mq.pop_front());
            end
            if (wb_pend_v)
            begin
                foreach (mq[i])
                begin
                    if (mq[i].tag == wb_pend.tag)
                    begin
                        mq[i] = wb_pend;
                    end
                end
            end
            wb_pend_v = st_issue_v_i && !rob_mispredict_i;
            wb_pend   = '{alloc_tag, 1'b1, st_issue_i.base + st_issue_i.offset, st_issue_i.data};
            if (st_issue_v_i)
            begin
                mq.push_back('{alloc_tag, 1'b0, '0, '0});
                alloc_tag = alloc_tag + 1'b1;
            end
            if (rob_mispredict_i)
            begin
                mq.delete();
                alloc_tag = '0;
                wb_pend_v = 1'b0;
            end
        end
        head_v <= (mq.size() > 0);
        head   <= (mq.size() > 0) ? mq[0] : '0;
    end

    // one clock of stimulus
    task automatic cycle(input logic sv, input st_issue_t s, input logic lv, input ld_req_t l,
                         input logic c, input logic m);
        @(posedge clk_i);
        st_issue_v_i     <= sv;
        st_issue_i       <= s;
        ld_issue_v_i     <= lv;
        ld_issue_i       <= l;
        rob_commit_st_i  <= c;
        rob_mispredict_i <= m;
        if (c && (sq_tag.size() > 0))
        begin
            void'(sq_tag.pop_front());
            void'(sq_step.pop_front());
        end
        if (sv)
        begin
            sq_tag.push_back(next_tag);
            sq_step.push_back(step);
            next_tag = next_tag + 1'b1;
        end
        if (m)
        begin
            sq_tag.delete();
            sq_step.delete();
            next_tag = '0;
        end
        step++;
    endtask

    task automatic idle(input int n);
        repeat (n) cycle(1'b0, '0, 1'b0, '0, 1'b0, 1'b0);
    endtask

    task automatic store(input word_t base, input word_t off, input word_t data);
        cycle(1'b1, '{base, off, data}, 1'b0, '0, 1'b0, 1'b0);
    endtask

    task automatic load(input word_t base, input word_t off, input logic older,
                        input sb_idx_t tag);
        cycle(1'b0, '0, 1'b1, '{base, off, tag, older}, 1'b0, 1'b0);
    endtask

    // wait until the head store has been written back
    task automatic commit_one();
        while (sq_step[0] + 2 > step)
        begin
            idle(1);
        end
        cycle(1'b0, '0, 1'b0, '0, 1'b1, 1'b0);
    endtask

    // outputs read in the middle of one idle cycle
    task automatic check_ready(input logic ready, input sb_idx_t entry);
        idle(1);
        @(negedge clk_i);
        if (st_ready_o !== ready)
        begin
            tb_err++;
            $display("Mismatch st_ready_o: got %h expected %h", st_ready_o, ready);
        end
        if (st_entry_o !== entry)
        begin
            tb_err++;
            $display("Mismatch st_entry_o: got %h expected %h", st_entry_o, entry);
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        idle(4);
        errs = chk_err + tb_err - err_base;
        tests_run++;
        $display("test %0d %s: %s, %0d errors", tests_run, name,
                 (errs == 0) ? "ok" : "failed", errs);
        err_base = chk_err + tb_err;
    endtask

    initial
    begin
        #(TEST_CYCLES * 20 + 2000);
        $display("timeout: the tests did not finish in the expected time");
        $display("** FAIL **");
        $finish;
    end

    initial
    begin
        int op;
        word_t off;
        seed = 32'h3809_2f30;
        foreach (model_mem[i])
        begin
            model_mem[i] = '0;
        end
        {st_issue_v_i, ld_issue_v_i, rob_commit_st_i, rob_mispredict_i} = '0;
        st_issue_i = '0;
        ld_issue_i = '0;
        reset_i    = 1'b1;
        next_tag   = '0;
        {step, tb_err, tests_run, err_base} = '0;
        repeat (3) @(posedge clk_i);
        reset_i <= 1'b0;

        store(32'h10, 32'h0, 32'h1111_0001);
        store(32'h10, 32'h4, 32'h2222_0002);
        store(32'h10, 32'h8, 32'h3333_0003);
        repeat (3) commit_one();
        end_test("commit order");

        store(32'h20, 32'h0, 32'hAAAA_0001);
        store(32'h1c, 32'h4, 32'hBBBB_0002);
        store(32'h40, 32'h0, 32'hCCCC_0003);
        idle(2);
        load(32'h20, 32'h0, 1'b1, sq_tag[$]);
        load(32'h10, 32'h0, 1'b1, sq_tag[$]);
        repeat (3) commit_one();
        end_test("youngest forward");

        store(32'h50, 32'h0, 32'hDDDD_0001);
        store(32'h30, 32'h0, 32'hEEEE_0002);
        idle(2);
        load(32'h30, 32'h0, 1'b1, sq_tag[0]);
        load(32'h30, 32'h0, 1'b0, '0);
        repeat (2) commit_one();
        end_test("age window");

        repeat (SB_ENTRY) store(32'h60, 32'h4, $random(seed));
        check_ready(1'b0, next_tag);
        commit_one();
        idle(1);
        check_ready(1'b1, next_tag);
        repeat (SB_ENTRY - 1) commit_one();
        end_test("full buffer");

        store(32'h70, 32'h0, 32'h7777_0001);
        store(32'h74, 32'h0, 32'h7777_0002);
        idle(2);
        load(32'h70, 32'h0, 1'b1, sq_tag[$]);
        load(32'h74, 32'h0, 1'b1, sq_tag[$]);
        cycle(1'b0, '0, 1'b0, '0, 1'b0, 1'b1);
        // flushed stores must not retire on a later commit
        cycle(1'b0, '0, 1'b0, '0, 1'b1, 1'b0);
        check_ready(1'b1, '0);
        end_test("mispredict");

        for (int i = 0; i < RAND_OPS; i++)
        begin
            op  = $unsigned($random(seed)) % 4;
            off = 4 * ($unsigned($random(seed)) % 4);
            if ((op == 0) && (sq_tag.size() < SB_ENTRY))
                store(32'h100, off, $random(seed));
            else if ((op == 1) && (sq_tag.size() > 0) && (sq_step[0] + 2 <= step))
                commit_one();
            else if (op == 2)
                load(32'h100, off, sq_tag.size() > 0, (sq_tag.size() > 0) ? sq_tag[$] : '0);
            else
                idle(1);
        end
        while (sq_tag.size() > 0)
        begin
            commit_one();
        end
        end_test("random mix");

        $display("%0d tests, %0d checks, %0d errors", tests_run, chk_cnt, chk_err + tb_err);
        if (chk_err + tb_err == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// ==== dv/lsu_checker.sv ====
`timescale 1ns/1ns

module lsu_checker
(
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              rob_commit_st_i,
    input  logic              rob_mispredict_i,
    // oldest store of the reference model
    input  logic              head_v_i,
    input  logic              head_wb_i,
    input  core_pkg::word_t   head_addr_i,
    input  core_pkg::word_t   head_data_i,
    // expected load result, queued two cycles after issue
    input  logic              exp_ld_v_i,
    input  lsq_pkg::ld_res_t  exp_ld_i,
    // observed DUT outputs
    input  logic              ld_done_i,
    input  lsq_pkg::ld_res_t  ld_res_i,
    input  logic              mem_wr_v_i,
    input  core_pkg::word_t   mem_wr_addr_i,
    input  core_pkg::word_t   mem_wr_data_i,
    output int                err_cnt_o,
    output int                chk_cnt_o
);
    import core_pkg::*;
    import lsq_pkg::*;

    logic wr_exp;
    logic ld_exp;

    task automatic compare(input string name, input word_t got, input word_t exp);
        chk_cnt_o++;
        if (got !== exp)
        begin
            err_cnt_o++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    always @(posedge clk_i)
    begin
        if (reset_i)
        begin
            err_cnt_o = 0;
            chk_cnt_o = 0;
        end
        else
        begin
            // head retires only once written back
            wr_exp = rob_commit_st_i && head_v_i && head_wb_i;
            ld_exp = exp_ld_v_i && !rob_mispredict_i;
            compare("mem_wr_v_o", word_t'(mem_wr_v_i), word_t'(wr_exp));
            if (wr_exp && mem_wr_v_i)
            begin
                compare("mem_wr_addr_o", mem_wr_addr_i, head_addr_i);
                compare("mem_wr_data_o", mem_wr_data_i, head_data_i);
            end
            chk_cnt_o++;
            if (ld_done_i && !ld_exp)
            begin
                err_cnt_o++;
                $display("a load result appeared when none was expected");
            end
            else if (!ld_done_i && ld_exp)
            begin
                err_cnt_o++;
                $display("an expected load result did not appear");
            end
            else if (ld_done_i)
            begin
                compare("ld_res_o.data", ld_res_i.data, exp_ld_i.data);
                compare("ld_res_o.fwd", word_t'(ld_res_i.fwd), word_t'(exp_ld_i.fwd));
            end
        end
    end

endmodule

// ==== verilog/lsu_top.sv ====
`timescale 1ns/1ns

module lsu_top
(
    input  logic                clk_i,
    input  logic                reset_i,
    // store issue
    input  logic                st_issue_v_i,
    input  lsq_pkg::st_issue_t  st_issue_i,
    output logic                st_ready_o,
    output lsq_pkg::sb_idx_t    st_entry_o,
    // load issue and result
    input  logic                ld_issue_v_i,
    input  lsq_pkg::ld_req_t    ld_issue_i,
    output logic                ld_done_o,
    output lsq_pkg::ld_res_t    ld_res_o,
    // rob
    input  logic                rob_commit_st_i,
    input  logic                rob_mispredict_i,
    // committed store write
    output logic                mem_wr_v_o,
    output core_pkg::word_t     mem_wr_addr_o,
    output core_pkg::word_t     mem_wr_data_o
);
    import core_pkg::*;
    import lsq_pkg::*;

    logic    sb_wb_v;
    sb_wb_t  sb_wb;
    word_t   fwd_addr;
    sb_idx_t fwd_newest;
    logic    fwd_v;
    word_t   fwd_data;
    word_t   mem_rd_addr;
    word_t   mem_rd_data;

    store_buffer store_buffer_inst
    (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .alloc_v_i        (st_issue_v_i),
        .alloc_entry_o    (st_entry_o),
        .alloc_ready_o    (st_ready_o),
        .rob_commit_st_i  (rob_commit_st_i),
        .rob_mispredict_i (rob_mispredict_i),
        .sb_wb_v_i        (sb_wb_v),
        .sb_wb_i          (sb_wb),
        .fwd_addr_i       (fwd_addr),
        .fwd_newest_i     (fwd_newest),
        .fwd_v_o          (fwd_v),
        .fwd_data_o       (fwd_data),
        .mem_wr_v_o       (mem_wr_v_o),
        .mem_wr_addr_o    (mem_wr_addr_o),
        .mem_wr_data_o    (mem_wr_data_o)
    );

    store_agu store_agu_inst
    (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .st_issue_v_i     (st_issue_v_i),
        .st_issue_i       (st_issue_i),
        .st_entry_i       (st_entry_o),
        .rob_mispredict_i (rob_mispredict_i),
        .sb_wb_v_o        (sb_wb_v),
        .sb_wb_o          (sb_wb)
    );

    load_unit load_unit_inst
    (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .ld_issue_v_i     (ld_issue_v_i),
        .ld_issue_i       (ld_issue_i),
        .rob_mispredict_i (rob_mispredict_i),
        .fwd_addr_o       (fwd_addr),
        .fwd_newest_o     (fwd_newest),
        .fwd_v_i          (fwd_v),
        .fwd_data_i       (fwd_data),
        .mem_rd_addr_o    (mem_rd_addr),
        .mem_rd_data_i    (mem_rd_data),
        .ld_done_o        (ld_done_o),
        .ld_res_o         (ld_res_o)
    );

    data_mem data_mem_inst
    (
        .clk_i            (clk_i),
        .wr_v_i           (mem_wr_v_o),
        .wr_addr_i        (mem_wr_addr_o),
        .wr_data_i        (mem_wr_data_o),
        .rd_addr_i        (mem_rd_addr),
        .rd_data_o        (mem_rd_data)
    );

endmodule

// ==== verilog/data_mem.sv ====
`timescale 1ns/1ns

module data_mem
(
    input  logic               clk_i,
    // commit write port
    input  logic               wr_v_i,
    input  core_pkg::word_t    wr_addr_i,
    input  core_pkg::word_t    wr_data_i,
    // load read port
    input  core_pkg::word_t    rd_addr_i,
    output core_pkg::word_t    rd_data_o
);
    import core_pkg::*;

    word_t    mem [MEM_WORDS];
    mem_idx_t wr_idx;
    mem_idx_t rd_idx;

    // word index, byte offset dropped
    assign wr_idx = wr_addr_i[BYTE_OFF_W +: MEM_IDX_W];
    assign rd_idx = rd_addr_i[BYTE_OFF_W +: MEM_IDX_W];

    initial
    begin
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            mem[i] = '0;
        end
    end

    // read returns the old word when both ports hit the same index
    always_ff @(posedge clk_i)
    begin
        if (wr_v_i)
        begin
            mem[wr_idx] <= wr_data_i;
        end
        rd_data_o <= mem[rd_idx];
    end

endmodule

// ==== verilog/load_unit.sv ====
`timescale 1ns/1ns

module load_unit
(
    input  logic               clk_i,
    input  logic               reset_i,
    // issued load
    input  logic               ld_issue_v_i,
    input  lsq_pkg::ld_req_t   ld_issue_i,
    input  logic               rob_mispredict_i,
    // forwarding query to the store buffer
    output core_pkg::word_t    fwd_addr_o,
    output lsq_pkg::sb_idx_t   fwd_newest_o,
    input  logic               fwd_v_i,
    input  core_pkg::word_t    fwd_data_i,
    // data memory read port
    output core_pkg::word_t    mem_rd_addr_o,
    input  core_pkg::word_t    mem_rd_data_i,
    // result
    output logic               ld_done_o,
    output lsq_pkg::ld_res_t   ld_res_o
);
    import core_pkg::*;
    import lsq_pkg::*;

    word_t   ld_addr;

    // stage 1, address and age tag
    logic    s1_v_q;
    word_t   s1_addr_q;
    sb_idx_t s1_newest_q;
    logic    s1_older_q;

    // stage 2, forwarding answer while memory data arrives
    logic    s2_v_q;
    logic    s2_fwd_q;
    word_t   s2_fwd_data_q;

    assign ld_addr = ld_issue_i.base + ld_issue_i.offset;

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            s1_v_q <= 1'b0;
            s2_v_q <= 1'b0;
        end
        else
        begin
            s1_v_q <= ld_issue_v_i & ~rob_mispredict_i;
            s2_v_q <= s1_v_q & ~rob_mispredict_i;
        end
    end

    always_ff @(posedge clk_i)
    begin
        s1_addr_q   <= ld_addr;
        s1_newest_q <= ld_issue_i.newest;
        s1_older_q  <= ld_issue_i.has_older;
        // no older store means nothing can forward
        s2_fwd_q      <= s1_older_q & fwd_v_i;
        s2_fwd_data_q <= fwd_data_i;
    end

    // query and memory read share the stage 1 address
    assign fwd_addr_o    = s1_addr_q;
    assign fwd_newest_o  = s1_newest_q;
    assign mem_rd_addr_o = s1_addr_q;

    // a load leaving while the flush is up is killed too
    assign ld_done_o     = s2_v_q & ~rob_mispredict_i;
    assign ld_res_o.fwd  = s2_fwd_q;
    assign ld_res_o.data = s2_fwd_q ? s2_fwd_data_q : mem_rd_data_i;

endmodule

// ==== verilog/store_agu.sv ====
`timescale 1ns/1ns

module store_agu
(
    input  logic                clk_i,
    input  logic                reset_i,
    // issued store and the entry it was given
    input  logic                st_issue_v_i,
    input  lsq_pkg::st_issue_t  st_issue_i,
    input  lsq_pkg::sb_idx_t    st_entry_i,
    input  logic                rob_mispredict_i,
    // write-back into the store buffer
    output logic                sb_wb_v_o,
    output lsq_pkg::sb_wb_t     sb_wb_o
);
    import core_pkg::*;
    import lsq_pkg::*;

    word_t  st_addr;
    logic   wb_v_q;
    sb_wb_t wb_q;

    // effective address
    assign st_addr = st_issue_i.base + st_issue_i.offset;

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            wb_v_q <= 1'b0;
        end
        else
        begin
            // a flush drops the write-back still in this stage
            wb_v_q <= st_issue_v_i & ~rob_mispredict_i;
        end
    end

    // payload only follows a valid issue
    always_ff @(posedge clk_i)
    begin
        if (st_issue_v_i)
        begin
            wb_q.dest <= st_entry_i;
            wb_q.addr <= st_addr;
            wb_q.data <= st_issue_i.data;
        end
    end

    assign sb_wb_v_o = wb_v_q;
    assign sb_wb_o   = wb_q;

endmodule

// ==== verilog/store_buffer.sv ====
`timescale 1ns/1ns

module store_buffer
(
    input  logic               clk_i,
    input  logic               reset_i,
    // allocation from issue
    input  logic               alloc_v_i,
    output lsq_pkg::sb_idx_t   alloc_entry_o,
    output logic               alloc_ready_o,
    // rob side
    input  logic               rob_commit_st_i,
    input  logic               rob_mispredict_i,
    // write-back from the store address unit
    input  logic               sb_wb_v_i,
    input  lsq_pkg::sb_wb_t    sb_wb_i,
    // load forwarding query
    input  core_pkg::word_t    fwd_addr_i,
    input  lsq_pkg::sb_idx_t   fwd_newest_i,
    output logic               fwd_v_o,
    output core_pkg::word_t    fwd_data_o,
    // commit write to memory
    output logic               mem_wr_v_o,
    output core_pkg::word_t    mem_wr_addr_o,
    output core_pkg::word_t    mem_wr_data_o
);
    import core_pkg::*;
    import lsq_pkg::*;

    sb_entry_t [SB_ENTRY-1:0] sb_q;
    sb_entry_t [SB_ENTRY-1:0] sb_n;
    sb_idx_t                  alloc_q;
    sb_idx_t                  alloc_n;
    sb_idx_t                  commit_q;
    sb_idx_t                  commit_n;
    sb_cnt_t                  free_q;
    sb_cnt_t                  free_n;

    // forwarding search
    logic [SB_ENTRY-1:0]      match_vec;
    logic [SB_ENTRY-1:0]      rot_match;
    sb_idx_t                  newest_off;
    sb_idx_t                  hit_off;
    sb_idx_t                  hit_idx;
    logic                     hit;

    assign alloc_entry_o = alloc_q;
    assign alloc_ready_o = (free_q != '0) && !rob_mispredict_i;

    // head retires only once its address and data are known
    assign mem_wr_v_o    = rob_commit_st_i & sb_q[commit_q].wb;
    assign mem_wr_addr_o = sb_q[commit_q].addr;
    assign mem_wr_data_o = sb_q[commit_q].data;

    always_comb
    begin
        sb_n     = sb_q;
        alloc_n  = alloc_q;
        commit_n = commit_q;
        free_n   = free_q;

        // new store, not yet written back
        if (alloc_v_i)
        begin
            sb_n[alloc_q].wb = 1'b0;
            alloc_n          = alloc_q + 1'b1;
            free_n           = free_n - 1'b1;
        end

        if (sb_wb_v_i)
        begin
            sb_n[sb_wb_i.dest].wb   = 1'b1;
            sb_n[sb_wb_i.dest].addr = sb_wb_i.addr;
            sb_n[sb_wb_i.dest].data = sb_wb_i.data;
        end

        if (mem_wr_v_o)
        begin
            sb_n[commit_q].wb = 1'b0;
            commit_n          = commit_q + 1'b1;
            free_n            = free_n + 1'b1;
        end

        // wrong path, drop every uncommitted store
        if (rob_mispredict_i)
        begin
            sb_n     = '0;
            alloc_n  = '0;
            commit_n = '0;
            free_n   = sb_cnt_t'(SB_ENTRY);
        end
    end

    // written-back entries holding the queried address
    always_comb
    begin
        match_vec = '0;
        for (int i = 0; i < SB_ENTRY; i++)
        begin
            if (sb_q[i].wb && (sb_q[i].addr == fwd_addr_i))
            begin
                match_vec[i] = 1'b1;
            end
        end
    end

    // reorder so bit 0 is the oldest entry
    always_comb
    begin
        for (int i = 0; i < SB_ENTRY; i++)
        begin
            rot_match[i] = match_vec[sb_idx_t'(commit_q + sb_idx_t'(i))];
        end
    end

    assign newest_off = fwd_newest_i - commit_q;

    // last hit in age order is the youngest one
    always_comb
    begin
        hit     = 1'b0;
        hit_off = '0;
        for (int i = 0; i < SB_ENTRY; i++)
        begin
            if (rot_match[i] && (sb_idx_t'(i) <= newest_off))
            begin
                hit     = 1'b1;
                hit_off = sb_idx_t'(i);
            end
        end
    end

    assign hit_idx    = hit_off + commit_q;
    assign fwd_v_o    = hit & ~rob_mispredict_i;
    assign fwd_data_o = sb_q[hit_idx].data;

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            sb_q     <= '0;
            alloc_q  <= '0;
            commit_q <= '0;
            free_q   <= sb_cnt_t'(SB_ENTRY);
        end
        else
        begin
            sb_q     <= sb_n;
            alloc_q  <= alloc_n;
            commit_q <= commit_n;
            free_q   <= free_n;
        end
    end

endmodule

// ==== verilog/lsq_pkg.sv ====
package lsq_pkg;

    // store buffer sizing
    localparam int SB_ENTRY = 8;
    localparam int SB_IDX_W = $clog2(SB_ENTRY);
    // free count needs one more bit to hold SB_ENTRY itself
    localparam int SB_CNT_W = SB_IDX_W + 1;

    typedef logic [SB_IDX_W-1:0] sb_idx_t;
    typedef logic [SB_CNT_W-1:0] sb_cnt_t;

    // one buffer entry
    typedef struct packed {
        logic            wb;
        core_pkg::word_t addr;
        core_pkg::word_t data;
    } sb_entry_t;

    // store write-back from the address unit
    typedef struct packed {
        sb_idx_t         dest;
        core_pkg::word_t addr;
        core_pkg::word_t data;
    } sb_wb_t;

    // issued store operands
    typedef struct packed {
        core_pkg::word_t base;
        core_pkg::word_t offset;
        core_pkg::word_t data;
    } st_issue_t;

    // issued load; newest is the youngest older store entry
    typedef struct packed {
        core_pkg::word_t base;
        core_pkg::word_t offset;
        sb_idx_t         newest;
        logic            has_older;
    } ld_req_t;

    typedef struct packed {
        core_pkg::word_t data;
        logic            fwd;
    } ld_res_t;

endpackage

// ==== verilog/core_pkg.sv ====
package core_pkg;

    // machine word, used for both addresses and data
    localparam int WORD_SIZE = 32;

    typedef logic [WORD_SIZE-1:0] word_t;

    // data memory geometry
    localparam int MEM_WORDS = 256;

    // byte offset inside one word, dropped when indexing the memory
    localparam int BYTE_OFF_W = $clog2(WORD_SIZE / 8);

    // word index taken from the address bits above the byte offset
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);

    typedef logic [MEM_IDX_W-1:0] mem_idx_t;

endpackage
